// File: design/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN 64

// first fetch after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

// register file size
`define RV_REG_NUM 32
`define RV_REG_AW 5

// major opcodes, inst[6:0]
`define RV_OP_IMM 7'b0010011
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_LUI 7'b0110111
`define RV_OP_JAL 7'b1101111
`define RV_OP_JALR 7'b1100111
`define RV_OP_STORE 7'b0100011
`define RV_OP_SYSTEM 7'b1110011

// funct3 values, inst[14:12]
`define RV_F3_ADDI 3'b000
`define RV_F3_JALR 3'b000
`define RV_F3_SD 3'b011
// ecall/ebreak group
`define RV_F3_PRIV 3'b000

`endif

// File: design/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  // instruction format seen by the operand mux
  typedef enum logic [2:0] {
    fmt_none,
    fmt_i,
    fmt_u,
    fmt_j
  } inst_fmt_e;

  // decoder result handed to execute
  typedef struct packed {
    // add is the only operation of the subset
    logic alu_add;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    // jump target operands
    logic [`RV_XLEN-1:0] op1_jump;
    logic [`RV_XLEN-1:0] op2_jump;
    logic jump_flag;
    logic rd_w_en;
    logic [`RV_REG_AW-1:0] rd_w_addr;
  } dec_t;

  // register read request
  typedef struct packed {
    logic rs1_r_en;
    logic [`RV_REG_AW-1:0] rs1_r_addr;
    logic rs2_r_en;
    logic [`RV_REG_AW-1:0] rs2_r_addr;
  } rd_req_t;

  // write-back payload
  typedef struct packed {
    logic en;
    logic [`RV_REG_AW-1:0] addr;
    logic [`RV_XLEN-1:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: design/pc_reg.sv
`default_nettype none

`include "rv_defines.svh"

module pc_reg (
  input logic clk,
  input logic rst,
  input logic jump_flag,
  input logic [`RV_XLEN-1:0] jump_target,
  input logic stop,
  input logic is_invalid,
  output logic [`RV_XLEN-1:0] pc,
  output logic halted,
  output logic illegal
);

  // jal/jalr targets drop bit 0
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (!halted && !stop) begin
      if (jump_flag) begin
        pc <= {jump_target[`RV_XLEN-1:1], 1'b0};
      end else begin
        pc <= pc + `RV_XLEN'(4);
      end
    end
  end

  // halt is sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
      illegal <= 1'b0;
    end else if (!halted && stop) begin
      halted <= 1'b1;
      // cause of the stop
      illegal <= is_invalid;
    end
  end

endmodule

`default_nettype wire

// File: design/idu.sv
`default_nettype none

`include "rv_defines.svh"

module idu (
  input logic [`RV_XLEN-1:0] pc,
  input logic [31:0] inst,
  input logic [`RV_XLEN-1:0] rs1_data,
  output rv_pkg::dec_t dec,
  output rv_pkg::rd_req_t rd_req,
  output logic inst_ebreak,
  output logic invalid_inst
);

  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic inst_addi;
  logic inst_auipc;
  logic inst_lui;
  logic inst_jal;
  logic inst_jalr;
  logic inst_sd;
  logic inst_dummy;
  inst_fmt_e fmt;

  // field split
  assign opcode = inst[6:0];
  assign rd = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1 = inst[19:15];

  // immediates, all sign extended to xlen
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  // J: imm[20|10:1|11|19:12]
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  // instruction match
  assign inst_addi = (opcode == `RV_OP_IMM) && (funct3 == `RV_F3_ADDI);
  assign inst_auipc = (opcode == `RV_OP_AUIPC);
  assign inst_lui = (opcode == `RV_OP_LUI);
  assign inst_jal = (opcode == `RV_OP_JAL);
  assign inst_jalr = (opcode == `RV_OP_JALR) && (funct3 == `RV_F3_JALR);
  // store decoded only, no memory behind it
  assign inst_sd = (opcode == `RV_OP_STORE) && (funct3 == `RV_F3_SD);
  assign inst_ebreak = (opcode == `RV_OP_SYSTEM) && (funct3 == `RV_F3_PRIV);
  // all-zero filler word
  assign inst_dummy = (inst == 32'h0);

  assign invalid_inst = !(inst_dummy | inst_addi | inst_ebreak | inst_auipc |
                          inst_lui | inst_jal | inst_jalr | inst_sd);

  // format, sd and dummy fall into none
  always_comb begin
    if (inst_addi || inst_jalr || inst_ebreak) begin
      fmt = fmt_i;
    end else if (inst_auipc || inst_lui) begin
      fmt = fmt_u;
    end else if (inst_jal) begin
      fmt = fmt_j;
    end else begin
      fmt = fmt_none;
    end
  end

  // operand select per format
  always_comb begin
    dec = '0;
    rd_req = '0;
    dec.alu_add = inst_addi | inst_auipc | inst_lui | inst_jal | inst_jalr;
    dec.jump_flag = inst_jal | inst_jalr;
    case (fmt)
      fmt_i: begin
        rd_req.rs1_r_en = 1'b1;
        rd_req.rs1_r_addr = rs1;
        // ebreak reads rs1 but never writes
        dec.rd_w_en = !inst_ebreak;
        dec.rd_w_addr = rd;
        if (inst_jalr) begin
          // link value, target from rs1
          dec.op1 = pc;
          dec.op2 = `RV_XLEN'(4);
          dec.op1_jump = rs1_data;
          dec.op2_jump = imm_i;
        end else begin
          dec.op1 = rs1_data;
          dec.op2 = imm_i;
        end
      end
      fmt_u: begin
        // lui adds to zero
        dec.op1 = inst_auipc ? pc : '0;
        dec.op2 = imm_u;
        dec.rd_w_en = 1'b1;
        dec.rd_w_addr = rd;
      end
      fmt_j: begin
        dec.op1 = pc;
        dec.op2 = `RV_XLEN'(4);
        dec.op1_jump = pc;
        dec.op2_jump = imm_j;
        dec.rd_w_en = 1'b1;
        dec.rd_w_addr = rd;
      end
      default: begin
        // no-op, nothing written
        dec.rd_w_en = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

`include "rv_defines.svh"

module regfile (
  input logic clk,
  input logic rst,
  input rv_pkg::rd_req_t rd_req,
  output logic [`RV_XLEN-1:0] rs1_data,
  input rv_pkg::wb_t wb
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

  // whole file cleared on reset
  // x0 is never written so it stays zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.addr != '0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // combinational read, same-cycle decode
  // no bypass, the write lands on the edge after
  always_comb begin
    if (!rd_req.rs1_r_en || (rd_req.rs1_r_addr == '0)) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rd_req.rs1_r_addr];
    end
  end

  // rs2 request fields come in with the struct
  // nothing in the subset reads rs2

endmodule

`default_nettype wire

// File: design/exu.sv
`default_nettype none

`include "rv_defines.svh"

module exu (
  input rv_pkg::dec_t dec,
  input logic halted,
  output rv_pkg::wb_t wb,
  output logic [`RV_XLEN-1:0] jump_target
);

  logic [`RV_XLEN-1:0] alu_sum;

  // result adder
  // covers addi, auipc, lui and the link value
  assign alu_sum = dec.op1 + dec.op2;

  // zero result when no add is selected
  assign wb.data = dec.alu_add ? alu_sum : '0;

  // target adder, bit 0 cleared in pc_reg
  assign jump_target = dec.op1_jump + dec.op2_jump;

  // rd passes straight through
  assign wb.addr = dec.rd_w_addr;

  // no write-back once the core has stopped
  assign wb.en = dec.rd_w_en && !halted;

endmodule

`default_nettype wire

// File: design/core_top.sv
`default_nettype none

`include "rv_defines.svh"

module core_top (
  input logic clk,
  input logic rst,
  input logic [31:0] inst,
  output logic [`RV_XLEN-1:0] pc,
  output rv_pkg::wb_t wb,
  output logic halted,
  output logic illegal
);

  import rv_pkg::*;

  dec_t dec;
  rd_req_t rd_req;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] jump_target;
  logic inst_ebreak;
  logic invalid_inst;
  logic stop;

  // either cause freezes the pc
  assign stop = inst_ebreak | invalid_inst;

  pc_reg pc_reg_inst (
    .clk(clk),
    .rst(rst),
    .jump_flag(dec.jump_flag),
    .jump_target(jump_target),
    .stop(stop),
    .is_invalid(invalid_inst),
    .pc(pc),
    .halted(halted),
    .illegal(illegal)
  );

  // inst arrives in the same cycle as pc
  idu idu_inst (
    .pc(pc),
    .inst(inst),
    .rs1_data(rs1_data),
    .dec(dec),
    .rd_req(rd_req),
    .inst_ebreak(inst_ebreak),
    .invalid_inst(invalid_inst)
  );

  regfile regfile_inst (
    .clk(clk),
    .rst(rst),
    .rd_req(rd_req),
    .rs1_data(rs1_data),
    .wb(wb)
  );

  // wb feeds the register file and the outputs
  exu exu_inst (
    .dec(dec),
    .halted(halted),
    .wb(wb),
    .jump_target(jump_target)
  );

endmodule

`default_nettype wire

// File: sim/inst_rom.sv
`default_nettype none

`include "rv_defines.svh"

// word-addressed program memory
// contents owned by the testbench
module inst_rom #(
  parameter int depth = 256
) (
  input logic [`RV_XLEN-1:0] pc,
  input logic [31:0] words [depth],
  output logic [31:0] inst
);

  logic [`RV_XLEN-1:0] offset;

  // byte offset from the reset vector
  assign offset = pc - `RV_RESET_PC;

  // word index, wraps inside the array
  assign inst = words[offset[$clog2(depth)+1:2]];

endmodule

`default_nettype wire

// File: sim/core_tb.sv
`default_nettype none

`include "rv_defines.svh"

module core_tb;

  import rv_pkg::*;

  localparam int rom_depth = 256;
  localparam int reset_cycles = 16;
  localparam int max_steps = 32;
  localparam int num_tests = 7;
  // raise, reset and program cycles per test plus margin
  localparam int cycle_limit = num_tests * (1 + reset_cycles + max_steps) + 50;
  localparam logic [31:0] ebreak_word = {12'd1, 5'd0, `RV_F3_PRIV, 5'd0, `RV_OP_SYSTEM};

  // one expected retirement
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic halted;
    logic illegal;
    wb_t wb;
  } expect_t;

  logic clk;
  logic rst;
  logic [31:0] inst;
  logic [`RV_XLEN-1:0] pc;
  wb_t wb;
  logic halted;
  logic illegal;
  logic [31:0] rom_words [rom_depth];

  // reference model state
  logic [`RV_XLEN-1:0] m_pc;
  logic [`RV_XLEN-1:0] m_regs [32];
  logic m_halted;
  logic m_illegal;
  expect_t exp_q [$];
  expect_t exp_cur;
  logic chk;
  logic [31:0] rng;
  int errors;
  int tests_run;
  int tests_failed;
  int cycles = 0;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  core_top core_top_inst (
    .clk(clk),
    .rst(rst),
    .inst(inst),
    .pc(pc),
    .wb(wb),
    .halted(halted),
    .illegal(illegal)
  );

  inst_rom #(.depth(rom_depth)) inst_rom_inst (
    .pc(pc),
    .words(rom_words),
    .inst(inst)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // addi and jalr share funct3 000
  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // J layout imm[20|10:1|11|19:12]
  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic int rom_index(input logic [`RV_XLEN-1:0] addr);
    logic [`RV_XLEN-1:0] off;
    off = addr - `RV_RESET_PC;
    return int'((off >> 2) % rom_depth);
  endfunction

  task automatic report_value(input string what, input logic [63:0] got,
                              input logic [63:0] want);
    $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, want);
    errors++;
  endtask

  // ISA rules for one word at the model pc
  task automatic predict(input logic [31:0] w);
    expect_t e;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] i_imm;
    logic [`RV_XLEN-1:0] u_imm;
    logic [`RV_XLEN-1:0] j_imm;
    logic [`RV_XLEN-1:0] src;
    logic is_sd;
    i_imm = {{52{w[31]}}, w[31:20]};
    u_imm = {{32{w[31]}}, w[31:12], 12'b0};
    j_imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    src = m_regs[w[19:15]];
    is_sd = (w[6:0] == `RV_OP_STORE) && (w[14:12] == `RV_F3_SD);
    e = '0;
    e.pc = m_pc;
    e.halted = m_halted;
    e.illegal = m_illegal;
    e.wb.addr = w[11:7];
    next_pc = m_pc + 4;
    if (m_halted) begin
      // frozen pc fetches the same word again
      next_pc = m_pc;
    end else if (w[6:0] == `RV_OP_IMM && w[14:12] == `RV_F3_ADDI) begin
      e.wb.en = 1'b1;
      e.wb.data = src + i_imm;
    end else if (w[6:0] == `RV_OP_LUI) begin
      e.wb.en = 1'b1;
      e.wb.data = u_imm;
    end else if (w[6:0] == `RV_OP_AUIPC) begin
      e.wb.en = 1'b1;
      e.wb.data = m_pc + u_imm;
    end else if (w[6:0] == `RV_OP_JAL) begin
      e.wb.en = 1'b1;
      e.wb.data = m_pc + 4;
      next_pc = m_pc + j_imm;
    end else if (w[6:0] == `RV_OP_JALR && w[14:12] == 3'b000) begin
      e.wb.en = 1'b1;
      e.wb.data = m_pc + 4;
      next_pc = (src + i_imm) & ~64'd1;
    end else if (w == ebreak_word) begin
      next_pc = m_pc;
      m_halted = 1'b1;
    end else if (w != 32'h0 && !is_sd) begin
      // not in the subset
      next_pc = m_pc;
      m_halted = 1'b1;
      m_illegal = 1'b1;
    end
    // x0 stays zero
    if (e.wb.en && e.wb.addr != 5'd0) begin
      m_regs[e.wb.addr] = e.wb.data;
    end
    m_pc = next_pc;
    exp_q.push_back(e);
  endtask

  // place a word at the model pc and step the model
  task automatic emit(input logic [31:0] w);
    rom_words[rom_index(m_pc)] = w;
    predict(w);
  endtask

  // cycles spent on the halting word
  task automatic hold(input int n);
    repeat (n) predict(rom_words[rom_index(m_pc)]);
  endtask

  // fill words carry the invalid opcode 1111111
  task automatic new_program();
    for (int i = 0; i < rom_depth; i++) begin
      rom_words[i] = {i[24:0], 7'b1111111};
    end
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    m_pc = `RV_RESET_PC;
    m_halted = 1'b0;
    m_illegal = 1'b0;
    exp_q.delete();
  endtask

  task automatic begin_test();
    @(posedge clk);
    #1;
    rst = 1'b1;
    new_program();
  endtask

  // one check per queued retirement
  task automatic check_steps(input string name);
    int errors_before;
    errors_before = errors;
    foreach (exp_q[k]) begin
      exp_cur = exp_q[k];
      chk = 1'b1;
      @(posedge clk);
      #1;
    end
    chk = 1'b0;
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: pass, %0d cycles checked", name, exp_q.size());
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic run_program(input string name);
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    check_steps(name);
  endtask

  // outputs settle mid cycle
  always @(negedge clk) begin
    if (chk) begin
      assert (pc == exp_cur.pc) else report_value("pc", pc, exp_cur.pc);
      assert (halted == exp_cur.halted) else report_value("halted", halted, exp_cur.halted);
      assert (illegal == exp_cur.illegal) else report_value("illegal", illegal, exp_cur.illegal);
      assert (wb.en == exp_cur.wb.en) else report_value("wb.en", wb.en, exp_cur.wb.en);
      // addr and data only matter on a write
      if (exp_cur.wb.en) begin
        assert (wb.addr == exp_cur.wb.addr) else report_value("wb.addr", wb.addr, exp_cur.wb.addr);
        assert (wb.data == exp_cur.wb.data) else report_value("wb.data", wb.data, exp_cur.wb.data);
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    chk = 1'b0;
    exp_cur = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rng = 32'd29079;
    new_program();

    // zero word first so wb.en starts low
    begin_test();
    emit(32'h0);
    emit(ebreak_word);
    hold(3);
    run_program("reset");

    // random addi chain
    begin_test();
    repeat (20) begin
      rng = xorshift(rng);
      emit(enc_i(`RV_OP_IMM, rng[4:0], rng[9:5], rng[31:20]));
    end
    // write to x0 and read x0 back
    emit(enc_i(`RV_OP_IMM, 5'd0, 5'd7, 12'h7ff));
    emit(enc_i(`RV_OP_IMM, 5'd8, 5'd0, 12'h801));
    emit(ebreak_word);
    hold(2);
    run_program("addi");

    begin_test();
    rng = xorshift(rng);
    emit(enc_u(`RV_OP_LUI, 5'd1, rng[19:0]));
    // negative upper immediate
    emit(enc_u(`RV_OP_LUI, 5'd2, 20'hfffff));
    emit(enc_u(`RV_OP_AUIPC, 5'd3, rng[31:12]));
    emit(enc_u(`RV_OP_AUIPC, 5'd4, 20'h80000));
    emit(enc_i(`RV_OP_IMM, 5'd5, 5'd2, 12'h001));
    emit(ebreak_word);
    run_program("lui_auipc");

    // skipped words hold invalid fill
    begin_test();
    emit(enc_jal(5'd1, 21'd12));
    emit(enc_u(`RV_OP_AUIPC, 5'd6, 20'd0));
    // odd offset drops target bit 0
    emit(enc_i(`RV_OP_JALR, 5'd7, 5'd6, 12'd17));
    emit(enc_i(`RV_OP_IMM, 5'd8, 5'd7, 12'd0));
    emit(enc_jal(5'd0, 21'd8));
    emit(ebreak_word);
    run_program("jumps");

    // x1 left by the jumps test reads zero after reset
    begin_test();
    emit(enc_i(`RV_OP_IMM, 5'd1, 5'd1, 12'd5));
    emit(ebreak_word);
    hold(5);
    run_program("ebreak");

    // writing word swapped in under the frozen pc without a reset
    rom_words[rom_index(m_pc)] = enc_i(`RV_OP_IMM, 5'd2, 5'd0, 12'd9);
    exp_q.delete();
    hold(3);
    check_steps("halted_write");

    // sd and zero word retire quietly and an R-type opcode stops the core
    begin_test();
    emit({7'd0, 5'd2, 5'd1, `RV_F3_SD, 5'd8, `RV_OP_STORE});
    emit(32'h0);
    emit(enc_i(`RV_OP_IMM, 5'd1, 5'd0, 12'd1));
    emit(enc_i(7'b0110011, 5'd1, 5'd1, 12'd0));
    hold(4);
    run_program("illegal");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/rv_pkg.sv
design/pc_reg.sv
design/idu.sv
design/regfile.sv
design/exu.sv
design/core_top.sv
sim/inst_rom.sv
sim/core_tb.sv

// File: Makefile
sim:
	rm -f sim.log
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module core_tb -Mdir obj_dir
	./obj_dir/Vcore_tb | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
